// File: avg_collector.sv
// Merges lane averages into one tagged result stream with power and gathers window-full flags
`include "iq_avg_defs.svh"

module avg_collector (
    input  logic                     clk,
    input  logic                     rstn,
    input  sample_pkg::iq_sample_t   lane_avg [`IQ_NUM_ANT],
    input  logic [`IQ_NUM_ANT-1:0]   lane_avg_valid,
    input  lane_pkg::lane_state_t    lane_state [`IQ_NUM_ANT],
    output sample_pkg::avg_result_t  out_result,
    output logic                     out_valid,
    output lane_pkg::lane_status_t   lane_status
);

    localparam int NUM_ANT = `IQ_NUM_ANT;
    localparam int ANT_W = `IQ_ANT_W;
    localparam int DATA_W = `IQ_DATA_W;
    localparam int POWER_W = `IQ_POWER_W;

    logic [ANT_W-1:0]          sel_ant;
    sample_pkg::iq_sample_t    sel_iq;
    logic signed [2*DATA_W-1:0] i_sq;
    logic signed [2*DATA_W-1:0] q_sq;
    logic [POWER_W-1:0]        power;
    logic [NUM_ANT-1:0]        full_mask;

    // Lane latencies are equal, so at most one valid is high
    always_comb begin
        sel_ant = '0;
        sel_iq  = '0;
        for (int k = 0; k < NUM_ANT; k++) begin
            if (lane_avg_valid[k]) begin
                sel_ant = ANT_W'(k);
                sel_iq  = lane_avg[k];
            end
        end
    end

    assign i_sq  = sel_iq.i * sel_iq.i; // Never negative
    assign q_sq  = sel_iq.q * sel_iq.q;
    assign power = {1'b0, i_sq} + {1'b0, q_sq};

    always_comb begin
        for (int k = 0; k < NUM_ANT; k++) begin
            full_mask[k] = (lane_state[k] == lane_pkg::LANE_SLIDING);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid   <= 1'b0;
            lane_status <= '0;
        end else begin
            out_valid            <= |lane_avg_valid;
            lane_status.win_full <= full_mask;
        end
    end

    always_ff @(posedge clk) begin
        out_result.ant   <= sel_ant;
        out_result.iq    <= sel_iq;
        out_result.power <= power;
    end

endmodule

// File: iq_avg_bank.sv
// Top level of the multi-antenna IQ averaging bank, dispatcher, lanes and collector
`include "iq_avg_defs.svh"

module iq_avg_bank (
    input  logic                       clk,
    input  logic                       rstn,
    input  sample_pkg::tagged_sample_t in_sample,
    input  logic                       in_valid,
    output sample_pkg::avg_result_t    out_result,
    output logic                       out_valid,
    output lane_pkg::lane_status_t     lane_status
);

    localparam int NUM_ANT = `IQ_NUM_ANT;

    sample_pkg::iq_sample_t  lane_sample;
    logic [NUM_ANT-1:0]      lane_valid;
    sample_pkg::iq_sample_t  lane_avg [NUM_ANT];
    logic [NUM_ANT-1:0]      lane_avg_valid;
    lane_pkg::lane_state_t   lane_state [NUM_ANT];

    sample_dispatch u_dispatch (
        .clk         (clk),
        .rstn        (rstn),
        .in_sample   (in_sample),
        .in_valid    (in_valid),
        .lane_sample (lane_sample),
        .lane_valid  (lane_valid)
    );

    // One lane per antenna
    for (genvar k = 0; k < NUM_ANT; k++) begin : g_lane
        mv_avg_dual_ch u_lane (
            .clk         (clk),
            .rstn        (rstn),
            .lane_sample (lane_sample),
            .lane_valid  (lane_valid[k]),
            .avg         (lane_avg[k]),
            .avg_valid   (lane_avg_valid[k]),
            .state       (lane_state[k])
        );
    end

    avg_collector u_collector (
        .clk            (clk),
        .rstn           (rstn),
        .lane_avg       (lane_avg),
        .lane_avg_valid (lane_avg_valid),
        .lane_state     (lane_state),
        .out_result     (out_result),
        .out_valid      (out_valid),
        .lane_status    (lane_status)
    );

endmodule

// File: iq_avg_defs.svh
// Shared width and size macros for the IQ averaging bank, included by packages, RTL and testbench
`ifndef IQ_AVG_DEFS_SVH
`define IQ_AVG_DEFS_SVH

// Width of signed I and of signed Q
`define IQ_DATA_W 16

// Window length is 2**IQ_LOG2_AVG_LEN samples
`define IQ_LOG2_AVG_LEN 5

// Antennas and lanes
`define IQ_NUM_ANT 4
`define IQ_ANT_W 2

// i*i + q*q of two full-scale values needs one bit more than a product
`define IQ_POWER_W (2 * `IQ_DATA_W + 1)

`endif

// File: lane_pkg.sv
// Lane control and status types used by the averaging lanes and the collector
`include "iq_avg_defs.svh"

package lane_pkg;

    // FILLING until the window holds its full length, then SLIDING
    typedef enum logic {
        LANE_FILLING,
        LANE_SLIDING
    } lane_state_t;

    // One window-full bit per antenna
    typedef struct packed {
        logic [`IQ_NUM_ANT-1:0] win_full;
    } lane_status_t;

endpackage

// File: mv_avg_dual_ch.sv
// One averaging lane, a sliding-window running average of I and Q for one antenna
`include "iq_avg_defs.svh"

module mv_avg_dual_ch (
    input  logic                    clk,
    input  logic                    rstn,
    input  sample_pkg::iq_sample_t  lane_sample,
    input  logic                    lane_valid,
    output sample_pkg::iq_sample_t  avg,
    output logic                    avg_valid,
    output lane_pkg::lane_state_t   state
);

    localparam int DATA_W = `IQ_DATA_W;
    localparam int LOG2_LEN = `IQ_LOG2_AVG_LEN;
    localparam int WIN_LEN = 1 << LOG2_LEN;
    localparam int TOT_W = DATA_W + LOG2_LEN; // Holds the sum of a full window

    sample_pkg::iq_sample_t   head;     // Oldest sample in the window
    logic [LOG2_LEN:0]        fifo_count;
    logic                     pop;
    logic                     valid_d1;
    logic signed [TOT_W-1:0]  tot_i;
    logic signed [TOT_W-1:0]  tot_q;
    logic signed [TOT_W-1:0]  add_i;
    logic signed [TOT_W-1:0]  add_q;
    logic signed [TOT_W-1:0]  sub_i;
    logic signed [TOT_W-1:0]  sub_q;

    sync_fifo #(
        .WIDTH      (2 * DATA_W),
        .DEPTH_LOG2 (LOG2_LEN)
    ) u_window (
        .clk   (clk),
        .rstn  (rstn),
        .wr_en (lane_valid),
        .din   (lane_sample),
        .rd_en (pop),
        .dout  (head),
        .count (fifo_count),
        .empty (),
        .full  ()
    );

    // Once sliding, every new sample pushes the oldest one out
    assign pop = lane_valid && (state == lane_pkg::LANE_SLIDING);

    always_comb begin
        add_i = lane_sample.i; // Sign extends
        add_q = lane_sample.q;
        sub_i = '0;
        sub_q = '0;
        if (pop) begin
            sub_i = head.i;
            sub_q = head.q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= lane_pkg::LANE_FILLING;
            tot_i     <= '0;
            tot_q     <= '0;
            valid_d1  <= 1'b0;
            avg_valid <= 1'b0;
        end else begin
            valid_d1  <= lane_valid;
            avg_valid <= valid_d1;
            if (lane_valid) begin
                tot_i <= tot_i + add_i - sub_i;
                tot_q <= tot_q + add_q - sub_q;
                // This write fills the window
                if (state == lane_pkg::LANE_FILLING &&
                    fifo_count == (LOG2_LEN+1)'(WIN_LEN - 1)) begin
                    state <= lane_pkg::LANE_SLIDING;
                end
            end
        end
    end

    // Arithmetic shift by the window exponent, floor division
    always_ff @(posedge clk) begin
        avg.i <= tot_i[TOT_W-1:LOG2_LEN];
        avg.q <= tot_q[TOT_W-1:LOG2_LEN];
    end

endmodule

// File: project.f
+incdir+.
sample_pkg.sv
lane_pkg.sv
sync_fifo.sv
mv_avg_dual_ch.sv
sample_dispatch.sv
avg_collector.sv
iq_avg_bank.sv
tb_checker.sv
tb_iq_avg_bank.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_iq_avg_bank \
    -o sim_tb || exit 1
out=$(./obj_dir/sim_tb 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

// File: sample_dispatch.sv
// Registers incoming tagged samples and raises the valid of the addressed lane only
`include "iq_avg_defs.svh"

module sample_dispatch (
    input  logic                       clk,
    input  logic                       rstn,
    input  sample_pkg::tagged_sample_t in_sample,
    input  logic                       in_valid,
    output sample_pkg::iq_sample_t     lane_sample,
    output logic [`IQ_NUM_ANT-1:0]     lane_valid
);

    localparam int NUM_ANT = `IQ_NUM_ANT;

    logic [NUM_ANT-1:0] sel;
    logic               in_range;

    assign in_range = (int'(in_sample.ant) < NUM_ANT);

    always_comb begin
        sel = '0;
        for (int k = 0; k < NUM_ANT; k++) begin
            if (int'(in_sample.ant) == k) begin
                sel[k] = in_valid && in_range;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lane_valid <= '0;
        end else begin
            lane_valid <= sel; // One-hot or zero
        end
    end

    // Shared by all lanes, only the addressed one takes it
    always_ff @(posedge clk) begin
        if (in_valid) begin
            lane_sample <= in_sample.iq;
        end
    end

endmodule

// File: sample_pkg.sv
// Sample-path types shared by dispatcher, lanes, collector and testbench
`include "iq_avg_defs.svh"

package sample_pkg;

    // One complex baseband sample
    typedef struct packed {
        logic signed [`IQ_DATA_W-1:0] i;
        logic signed [`IQ_DATA_W-1:0] q;
    } iq_sample_t;

    // Sample with its antenna index, as it enters the bank
    typedef struct packed {
        logic [`IQ_ANT_W-1:0] ant;
        iq_sample_t           iq;
    } tagged_sample_t;

    // Averaged sample leaving the bank
    typedef struct packed {
        logic [`IQ_ANT_W-1:0]   ant;
        iq_sample_t             iq;    // Window average
        logic [`IQ_POWER_W-1:0] power; // Unsigned i*i + q*q
    } avg_result_t;

endpackage

// File: sync_fifo.sv
// Register-array synchronous FIFO with first-word fall-through, used as a lane window store
module sync_fifo #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 5
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  wr_en,
    input  logic [WIDTH-1:0]      din,
    input  logic                  rd_en,
    output logic [WIDTH-1:0]      dout,
    output logic [DEPTH_LOG2:0]   count,
    output logic                  empty,
    output logic                  full
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic                  do_wr;
    logic                  do_rd;

    assign empty = (count == '0);
    assign full  = (count == (DEPTH_LOG2+1)'(DEPTH));

    // A full FIFO still takes a write when the head leaves in the same cycle
    assign do_rd = rd_en && !empty;
    assign do_wr = wr_en && (!full || do_rd);

    assign dout = mem[rd_ptr]; // Fall-through head

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: tb_checker.sv
// Testbench checker that watches the averaging bank outputs and compares them with expected results
`include "iq_avg_defs.svh"

module tb_checker (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    out_valid,
    input  sample_pkg::avg_result_t out_result,
    input  lane_pkg::lane_status_t  lane_status,
    input  logic                    exp_push,
    input  sample_pkg::avg_result_t exp_result,
    input  logic [`IQ_NUM_ANT-1:0]  exp_status,
    input  logic                    end_check,
    output int                      mismatch_cnt,
    output int                      unexpected_cnt,
    output int                      leftover_cnt,
    output int                      pending
);

    localparam int LATENCY = 4;    // in_valid to out_valid
    localparam int STATUS_DLY = 3; // in_valid to lane_status

    sample_pkg::avg_result_t exp_q [$];
    int                      stamp_q [$]; // Cycle each expectation was driven
    logic [`IQ_NUM_ANT-1:0]  status_pipe [STATUS_DLY];
    int                      cycle = 0;
    int                      n_mismatch = 0;
    int                      n_unexpected = 0;
    int                      n_leftover = 0;
    int                      n_pending = 0;
    logic                    end_seen = 1'b0;

    assign mismatch_cnt   = n_mismatch;
    assign unexpected_cnt = n_unexpected;
    assign leftover_cnt   = n_leftover;
    assign pending        = n_pending;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic compare_field(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
        if (exp !== got) begin
            $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, got);
            n_mismatch++;
        end
    endtask

    // Outputs are sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin : watch_outputs
        sample_pkg::avg_result_t exp;
        int                      stamp;
        if (!rstn) begin
            for (int k = 0; k < STATUS_DLY; k++) begin
                status_pipe[k] = '0;
            end
        end else begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Result for antenna %0d came out with no sample pending",
                             out_result.ant);
                    n_unexpected++;
                end else begin
                    exp   = exp_q.pop_front();
                    stamp = stamp_q.pop_front();
                    compare_field("out_valid latency", LATENCY, cycle - stamp);
                    compare_field("out_result.ant", exp.ant, out_result.ant);
                    compare_field("out_result.iq.i", $unsigned(exp.iq.i),
                                  $unsigned(out_result.iq.i));
                    compare_field("out_result.iq.q", $unsigned(exp.iq.q),
                                  $unsigned(out_result.iq.q));
                    compare_field("out_result.power", exp.power, out_result.power);
                end
            end
            compare_field("lane_status", status_pipe[STATUS_DLY-1], lane_status.win_full);
            for (int k = STATUS_DLY - 1; k > 0; k--) begin
                status_pipe[k] = status_pipe[k-1];
            end
            status_pipe[0] = exp_status;
            if (exp_push) begin
                exp_q.push_back(exp_result);
                stamp_q.push_back(cycle);
            end
            if (end_check && !end_seen) begin
                end_seen = 1'b1;
                if (exp_q.size() != 0) begin
                    $display("%0d expected results never appeared on the output",
                             exp_q.size());
                    n_leftover += exp_q.size();
                end
            end
        end
        n_pending = exp_q.size();
    end

endmodule

// File: tb_iq_avg_bank.sv
// Testbench top for the IQ averaging bank with clock, reset, stimulus and the reference model
`include "iq_avg_defs.svh"

module tb_iq_avg_bank;

    localparam int NUM_ANT = `IQ_NUM_ANT;
    localparam int ANT_W = `IQ_ANT_W;
    localparam int WIN_LEN = 1 << `IQ_LOG2_AVG_LEN;
    localparam int DRAIN_TIMEOUT = 50;

    logic                       clk;
    logic                       rstn;
    sample_pkg::tagged_sample_t in_sample;
    logic                       in_valid;
    sample_pkg::avg_result_t    out_result;
    logic                       out_valid;
    lane_pkg::lane_status_t     lane_status;
    logic                       exp_push;
    sample_pkg::avg_result_t    exp_result;
    logic [NUM_ANT-1:0]         exp_status; // Antennas with a full window so far
    logic                       end_check;
    int                         mismatch_cnt;
    int                         unexpected_cnt;
    int                         leftover_cnt;
    int                         pending;
    int                         timeout_cnt;
    integer                     seed;
    logic signed [`IQ_DATA_W-1:0] hist_i [NUM_ANT][WIN_LEN]; // Last samples per antenna
    logic signed [`IQ_DATA_W-1:0] hist_q [NUM_ANT][WIN_LEN];
    int                         n_rx [NUM_ANT];

    iq_avg_bank dut (
        .clk         (clk),
        .rstn        (rstn),
        .in_sample   (in_sample),
        .in_valid    (in_valid),
        .out_result  (out_result),
        .out_valid   (out_valid),
        .lane_status (lane_status)
    );

    tb_checker u_checker (
        .clk            (clk),
        .rstn           (rstn),
        .out_valid      (out_valid),
        .out_result     (out_result),
        .lane_status    (lane_status),
        .exp_push       (exp_push),
        .exp_result     (exp_result),
        .exp_status     (exp_status),
        .end_check      (end_check),
        .mismatch_cnt   (mismatch_cnt),
        .unexpected_cnt (unexpected_cnt),
        .leftover_cnt   (leftover_cnt),
        .pending        (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic longint floor_div(input longint sum);
        longint quo;
        quo = sum / WIN_LEN; // Truncates toward zero
        if ((sum % WIN_LEN != 0) && (sum < 0)) begin
            quo = quo - 1;
        end
        return quo;
    endfunction

    // Expected result for the newest sample of one antenna
    function automatic sample_pkg::avg_result_t ref_avg(input int ant);
        sample_pkg::avg_result_t res;
        longint                  sum_i;
        longint                  sum_q;
        longint                  avg_i;
        longint                  avg_q;
        int                      n;
        n = (n_rx[ant] < WIN_LEN) ? n_rx[ant] : WIN_LEN;
        sum_i = 0;
        sum_q = 0;
        for (int k = 0; k < n; k++) begin
            sum_i += hist_i[ant][k];
            sum_q += hist_q[ant][k];
        end
        avg_i = floor_div(sum_i);
        avg_q = floor_div(sum_q);
        res.ant = ANT_W'(ant);
        res.iq.i = avg_i[`IQ_DATA_W-1:0];
        res.iq.q = avg_q[`IQ_DATA_W-1:0];
        res.power = `IQ_POWER_W'(avg_i * avg_i + avg_q * avg_q);
        return res;
    endfunction

    function automatic logic [`IQ_DATA_W-1:0] rand_word();
        integer r;
        r = $random(seed);
        return r[`IQ_DATA_W-1:0];
    endfunction

    task automatic send_sample(input logic [ANT_W-1:0] ant,
                               input logic signed [`IQ_DATA_W-1:0] i,
                               input logic signed [`IQ_DATA_W-1:0] q);
        int slot;
        @(posedge clk);
        #1;
        in_sample.ant  = ant;
        in_sample.iq.i = i;
        in_sample.iq.q = q;
        in_valid       = 1'b1;
        exp_push       = 1'b0;
        if (int'(ant) < NUM_ANT) begin
            slot = n_rx[ant] % WIN_LEN; // Oldest entry gets overwritten
            hist_i[ant][slot] = i;
            hist_q[ant][slot] = q;
            n_rx[ant]++;
            if (n_rx[ant] >= WIN_LEN) begin
                exp_status[ant] = 1'b1;
            end
            exp_result = ref_avg(int'(ant));
            exp_push   = 1'b1;
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            exp_push = 1'b0;
        end
    endtask

    // Average ramps up while filling, then holds the input
    task automatic run_constant(input logic [ANT_W-1:0] ant);
        for (int k = 0; k < WIN_LEN + 8; k++) begin
            send_sample(ant, 16'sd1000, -16'sd700);
        end
        idle_cycles(2);
    endtask

    task automatic run_sliding(input logic [ANT_W-1:0] ant);
        for (int k = 0; k < 3 * WIN_LEN; k++) begin
            send_sample(ant, rand_word(), rand_word());
        end
        idle_cycles(2);
    endtask

    task automatic run_interleaved();
        for (int k = 0; k < 200; k++) begin
            send_sample(ANT_W'(rand_word()), rand_word(), rand_word());
        end
        idle_cycles(2);
    endtask

    task automatic run_extremes();
        for (int k = 0; k < WIN_LEN + 8; k++) begin
            send_sample(2'd2, 16'sh7fff, 16'sh8000);
            send_sample(2'd3, 16'sh8000, 16'sh8000);
        end
        for (int k = 0; k < WIN_LEN + 8; k++) begin
            send_sample(2'd2, 16'sh8000, 16'sh7fff); // Swing full scale the other way
        end
        idle_cycles(2);
    endtask

    task automatic run_gaps();
        integer r;
        for (int k = 0; k < 120; k++) begin
            send_sample(ANT_W'(rand_word()), rand_word(), rand_word());
            r = $random(seed);
            idle_cycles(r[1:0]);
        end
        idle_cycles(2);
    endtask

    task automatic drain_output();
        int waited;
        waited = 0;
        while (pending != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("Timed out waiting for %0d pending results to come out", pending);
            timeout_cnt++;
        end
    endtask

    initial begin : main
        int total;
        seed        = 44;
        timeout_cnt = 0;
        rstn        = 1'b0;
        in_sample   = '0;
        in_valid    = 1'b0;
        exp_push    = 1'b0;
        exp_result  = '0;
        exp_status  = '0;
        end_check   = 1'b0;
        for (int a = 0; a < NUM_ANT; a++) begin
            n_rx[a] = 0;
            for (int k = 0; k < WIN_LEN; k++) begin
                hist_i[a][k] = '0;
                hist_q[a][k] = '0;
            end
        end
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        idle_cycles(6); // Outputs stay quiet with no input
        run_constant(2'd0);
        run_sliding(2'd1);
        run_interleaved();
        run_extremes();
        run_gaps();
        drain_output();
        end_check = 1'b1;
        repeat (2) @(posedge clk);
        total = mismatch_cnt + unexpected_cnt + leftover_cnt + timeout_cnt;
        $display("Errors: mismatch %0d, unexpected %0d, leftover %0d, timeout %0d",
                 mismatch_cnt, unexpected_cnt, leftover_cnt, timeout_cnt);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
